// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_fetch_top
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_TEXT = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only if the pass line shows up in the simulator output
test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: fetch_bram.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_bram (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Current fetch address from the PC register
  input  wire logic [`FETCH_XLEN-1:0]  pc,

  // Hazard control
  input  wire logic                    pc_stall,
  input  wire logic                    if_id_flush,

  // Instruction RAM
  output logic                         imem_ren,
  output logic      [`IMEM_AW-1:0]     imem_raddr,
  input  wire logic [`FETCH_XLEN-1:0]  imem_rdata,

  // Towards the IF/ID boundary
  output logic      [`FETCH_XLEN-1:0]  instr_id,
  output logic      [`FETCH_XLEN-1:0]  pc_to_if_id,
  output logic                         valid_to_if_id
);

  // Set when the RAM output register holds a word that belongs on the
  // current path
  logic in_flight;

  // Read every cycle unless the front end is frozen
  // A frozen RAM keeps its output, so the shown word stays put
  assign imem_ren = !pc_stall;

  // Byte address to word index, low two bits are always zero
  assign imem_raddr = pc[`IMEM_AW+1:2];

  // In-flight tracking
  // Flush kills the word currently being read, it still comes back
  // from the RAM next cycle but is never marked valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
    end else if (if_id_flush) begin
      in_flight <= 1'b0;
    end else if (imem_ren) begin
      in_flight <= 1'b1;
    end
  end

  // Address of the issued read
  // if_stage registers it under if_id_stall, the same condition under
  // which the RAM latches data, so pc_id lines up with imem_rdata
  assign pc_to_if_id = pc;

  // Instruction is taken straight from the RAM output register
  assign instr_id = imem_rdata;

  assign valid_to_if_id = in_flight;

endmodule

`default_nettype wire

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Data path width of the fetch front end
// One RV32 word, also the width of pc and every PC register
`define FETCH_XLEN 32

// First address fetched once reset is released
// Must be word aligned
`define FETCH_RESET_PC 32'h0000_0000

// Word address width of the instruction RAM
// 8 bits gives 256 words, so 1 KiB of code
`define IMEM_AW 8

`endif

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Source of the next fetch address
  // SEQUENTIAL takes pc + 4
  // PREDICTED takes the predecoder target of the word leaving IF
  // REDIRECT takes the target supplied by execute
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_PREDICTED  = 2'b01,
    PC_SEL_REDIRECT   = 2'b10
  } pc_sel_e;

endpackage

`default_nettype wire

// File: fetch_steer.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_steer
  import rv_isa_pkg::*;
  import fetch_pkg::*;
(
  // Instruction leaving IF
  input  wire logic [`FETCH_XLEN-1:0]  instr_id,
  input  wire logic [`FETCH_XLEN-1:0]  pc_id,
  input  wire logic                    valid_id,

  // Events from later stages
  input  wire logic                    redirect,
  input  wire logic                    id_stall,

  // Steering of the IF stage
  output pc_sel_e                      pc_sel,
  output logic      [`FETCH_XLEN-1:0]  pred_target,
  output logic                         pc_stall,
  output logic                         if_id_stall,
  output logic                         if_id_flush,

  // Travels with the instruction towards decode
  output logic                         pred_taken
);

  rv_instr_u              instr;
  logic                   is_jal;
  logic                   is_branch;
  logic [`FETCH_XLEN-1:0] j_off;
  logic [`FETCH_XLEN-1:0] b_off;
  logic                   pred_hit;

  assign instr = instr_id;

  // Opcode match through each decode view
  assign is_jal    = (instr.j_fmt.opcode == OPC_JAL);
  assign is_branch = (instr.b_fmt.opcode == OPC_BRANCH);

  // Offsets from both layouts
  // Only one of them is meaningful for a given opcode
  assign j_off = j_imm(instr);
  assign b_off = b_imm(instr);

  // Static rule
  // JAL always taken, branch taken only when it jumps backwards
  assign pred_hit = is_jal || (is_branch && b_off[`FETCH_XLEN-1]);

  assign pred_target = pc_id + (is_jal ? j_off : b_off);

  // Depends only on the shown instruction, so it holds through a stall
  assign pred_taken = valid_id && pred_hit;

  // Priority: redirect, then stall, then prediction
  always_comb begin
    pc_sel      = PC_SEL_SEQUENTIAL;
    pc_stall    = 1'b0;
    if_id_stall = 1'b0;
    if_id_flush = 1'b0;
    if (redirect) begin
      // Execute knows better, wrong-path word in flight is dropped
      pc_sel      = PC_SEL_REDIRECT;
      if_id_flush = 1'b1;
    end else if (id_stall) begin
      // Freeze PC, RAM read and IF/ID together
      pc_stall    = 1'b1;
      if_id_stall = 1'b1;
    end else if (pred_taken) begin
      // Sequential word behind the taken instruction is killed
      pc_sel      = PC_SEL_PREDICTED;
      if_id_flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: fetch_top.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Program load into the instruction RAM
  input  wire logic                    imem_we,
  input  wire logic [`IMEM_AW-1:0]     imem_waddr,
  input  wire logic [`FETCH_XLEN-1:0]  imem_wdata,

  // From execute and decode
  input  wire logic                    redirect,
  input  wire logic [`FETCH_XLEN-1:0]  redirect_target,
  input  wire logic                    id_stall,

  // Towards decode
  output logic      [`FETCH_XLEN-1:0]  instr,
  output logic      [`FETCH_XLEN-1:0]  pc,
  output logic      [`FETCH_XLEN-1:0]  pc_plus4,
  output logic                         pred_taken,
  output logic                         valid
);

  // RAM read port
  logic                   imem_ren;
  logic [`IMEM_AW-1:0]    imem_raddr;
  logic [`FETCH_XLEN-1:0] imem_rdata;

  // Steering between fetch_steer and if_stage
  pc_sel_e                pc_sel;
  logic [`FETCH_XLEN-1:0] pred_target;
  logic                   pc_stall;
  logic                   if_id_stall;
  logic                   if_id_flush;

  if_stage #(
    .RESET_PC(`FETCH_RESET_PC)
  ) i_if_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_stall          (pc_stall),
    .if_id_stall       (if_id_stall),
    .if_id_flush       (if_id_flush),
    .pc_sel            (pc_sel),
    .pc_redirect_target(redirect_target),
    .pred_target       (pred_target),
    .imem_ren          (imem_ren),
    .imem_raddr        (imem_raddr),
    .imem_rdata        (imem_rdata),
    .instr_id          (instr),
    .pc_id             (pc),
    .pc_plus4_id       (pc_plus4),
    .valid_id          (valid)
  );

  imem_bram #(
    .DEPTH_LOG2(`IMEM_AW)
  ) i_imem_bram (
    .clk  (clk),
    .ren  (imem_ren),
    .raddr(imem_raddr),
    .rdata(imem_rdata),
    .we   (imem_we),
    .waddr(imem_waddr),
    .wdata(imem_wdata)
  );

  // Predecode looks at the same word and pc that go to decode
  fetch_steer i_fetch_steer (
    .instr_id   (instr),
    .pc_id      (pc),
    .valid_id   (valid),
    .redirect   (redirect),
    .id_stall   (id_stall),
    .pc_sel     (pc_sel),
    .pred_target(pred_target),
    .pc_stall   (pc_stall),
    .if_id_stall(if_id_stall),
    .if_id_flush(if_id_flush),
    .pred_taken (pred_taken)
  );

endmodule

`default_nettype wire

// File: if_stage.sv
`default_nettype none

`include "fetch_macros.svh"

module if_stage
  import fetch_pkg::*;
#(
  parameter logic [`FETCH_XLEN-1:0] RESET_PC = `FETCH_RESET_PC
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Hazard control
  input  wire logic                    pc_stall,
  input  wire logic                    if_id_stall,
  input  wire logic                    if_id_flush,

  // Next-PC selection and its candidate targets
  input  wire pc_sel_e                 pc_sel,
  input  wire logic [`FETCH_XLEN-1:0]  pc_redirect_target,
  input  wire logic [`FETCH_XLEN-1:0]  pred_target,

  // Instruction RAM
  output logic                         imem_ren,
  output logic      [`IMEM_AW-1:0]     imem_raddr,
  input  wire logic [`FETCH_XLEN-1:0]  imem_rdata,

  // Towards decode
  output logic      [`FETCH_XLEN-1:0]  instr_id,
  output logic      [`FETCH_XLEN-1:0]  pc_id,
  output logic      [`FETCH_XLEN-1:0]  pc_plus4_id,
  output logic                         valid_id
);

  // Byte step between sequential instructions
  localparam logic [`FETCH_XLEN-1:0] PC_STEP = 4;

  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] pc_next;
  logic [`FETCH_XLEN-1:0] pc_to_if_id;

  // Next-PC mux
  // Redirect and prediction priority is resolved in fetch_steer
  always_comb begin
    case (pc_sel)
      PC_SEL_REDIRECT:   pc_next = pc_redirect_target;
      PC_SEL_PREDICTED:  pc_next = pred_target;
      PC_SEL_SEQUENTIAL: pc_next = pc + PC_STEP;
      default:           pc_next = pc + PC_STEP;
    endcase
  end

  // PC register
  // Starts on RESET_PC so the very first read after reset is the reset vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!pc_stall) begin
      pc <= pc_next;
    end
  end

  // Read sequencing against the registered RAM
  fetch_bram i_fetch_bram (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc            (pc),
    .pc_stall      (pc_stall),
    .if_id_flush   (if_id_flush),
    .imem_ren      (imem_ren),
    .imem_raddr    (imem_raddr),
    .imem_rdata    (imem_rdata),
    .instr_id      (instr_id),
    .pc_to_if_id   (pc_to_if_id),
    .valid_to_if_id(valid_id)
  );

  // IF/ID PC registers
  // Instruction and valid are already registered inside fetch_bram,
  // only the addresses need a stage here to meet the RAM data
  always_ff @(posedge clk) begin
    if (!if_id_stall) begin
      pc_id       <= pc_to_if_id;
      pc_plus4_id <= pc_to_if_id + PC_STEP;
    end
  end

endmodule

`default_nettype wire

// File: imem_bram.sv
`default_nettype none

`include "fetch_macros.svh"

module imem_bram #(
  parameter int DEPTH_LOG2 = `IMEM_AW
) (
  input  wire logic                    clk,

  // Fetch read port
  input  wire logic                    ren,
  input  wire logic [DEPTH_LOG2-1:0]   raddr,
  output logic      [`FETCH_XLEN-1:0]  rdata,

  // Load port
  input  wire logic                    we,
  input  wire logic [DEPTH_LOG2-1:0]   waddr,
  input  wire logic [`FETCH_XLEN-1:0]  wdata
);

  // Word storage, maps onto one block RAM
  logic [`FETCH_XLEN-1:0] mem[2**DEPTH_LOG2];

  // Program load, usable in and out of reset
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read port
  // Output register keeps its word while ren is low,
  // which is what lets a stalled fetch keep showing the same instruction
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes the predecoder cares about
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // J-type layout, immediate bits are scattered across the word
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // B-type layout, sign bit shares position 31 with the J view
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // Same fetched word read through either decode view
  typedef union packed {
    logic [31:0] word;
    j_fmt_t      j_fmt;
    b_fmt_t      b_fmt;
  } rv_instr_u;

  // Sign-extended JAL byte offset
  // Bit 0 is always zero
  function automatic logic [31:0] j_imm(rv_instr_u instr);
    return {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
            instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
  endfunction

  // Sign-extended conditional branch byte offset
  function automatic logic [31:0] b_imm(rv_instr_u instr);
    return {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
            instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  endfunction

endpackage

`default_nettype wire

// File: sources.f
+incdir+.
rv_isa_pkg.sv
fetch_pkg.sv
imem_bram.sv
fetch_bram.sv
if_stage.sv
fetch_steer.sv
fetch_top.sv
tb_fetch_top.sv

// File: tb_fetch_top.sv
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_top
  import rv_isa_pkg::*;
();

  localparam int IMEM_WORDS = 2 ** `IMEM_AW;
  // Deliveries per loop run
  // Eight passes over the eight-instruction loop
  localparam int RUN_LEN    = 64;
  // Load takes about 260 cycles
  // Loop runs stay well below 800 cycles even at 50 % stall
  localparam int MAX_CYCLES = 4000;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // Loop with forward branch, forward JAL and backward branch
  localparam logic [`FETCH_XLEN-1:0] LOOP_BASE = 32'h0000_0040;
  // Tight loop closed by a backward JAL
  localparam logic [`FETCH_XLEN-1:0] JAL_BASE  = 32'h0000_0098;

  logic                   clk;
  logic                   rst_n;
  logic                   imem_we;
  logic [`IMEM_AW-1:0]    imem_waddr;
  logic [`FETCH_XLEN-1:0] imem_wdata;
  logic                   redirect;
  logic [`FETCH_XLEN-1:0] redirect_target;
  logic                   id_stall;
  logic [`FETCH_XLEN-1:0] instr;
  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] pc_plus4;
  logic                   pred_taken;
  logic                   valid;

  // Reference copy of the RAM with the expected prediction per word
  logic [`FETCH_XLEN-1:0] model_mem[IMEM_WORDS];
  logic                   model_pred[IMEM_WORDS];
  logic [`FETCH_XLEN-1:0] model_tgt[IMEM_WORDS];

  // Checker state
  logic                   tracking;
  logic                   exp_valid;
  logic [`FETCH_XLEN-1:0] exp_pc;
  logic [`IMEM_AW-1:0]    exp_idx;
  logic                   hold_prev;
  logic [`FETCH_XLEN-1:0] prev_instr;
  logic [`FETCH_XLEN-1:0] prev_pc;
  logic [`FETCH_XLEN-1:0] prev_pc_plus4;
  logic                   prev_pred;
  logic                   prev_valid;
  int                     delivered_cnt;
  int                     cycle_cnt;
  // 1 records into the unstalled queue and 2 into the stalled one
  int                     record_sel;
  logic [`FETCH_XLEN-1:0] pcs_plain[$];
  logic [`FETCH_XLEN-1:0] pcs_stalled[$];

  assign exp_idx = exp_pc[`IMEM_AW+1:2];

  fetch_top i_fetch_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_we        (imem_we),
    .imem_waddr     (imem_waddr),
    .imem_wdata     (imem_wdata),
    .redirect       (redirect),
    .redirect_target(redirect_target),
    .id_stall       (id_stall),
    .instr          (instr),
    .pc             (pc),
    .pc_plus4       (pc_plus4),
    .pred_taken     (pred_taken),
    .valid          (valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [`FETCH_XLEN-1:0] got,
                          input logic [`FETCH_XLEN-1:0] exp);
    $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    stop_run();
  endtask

  task automatic abort_with(input string what);
    $display("%s", what);
    stop_run();
  endtask

  // Encoders follow the RV32I base formats
  function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
    logic [31:0] imm;
    imm = off;
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input int off);
    logic [31:0] imm;
    imm = off;
    // rs2 = x0 and rs1 = x1
    return {imm[12], imm[10:5], 5'd0, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
  endfunction

  // JAL is always predicted with target pc + offset
  task automatic add_jal(input int idx, input int off);
    model_mem[idx]  = jal_word(5'd0, off);
    model_pred[idx] = 1'b1;
    model_tgt[idx]  = idx * 4 + off;
  endtask

  // Only a backward branch is predicted taken
  task automatic add_branch(input int idx, input logic [2:0] f3, input int off);
    model_mem[idx]  = branch_word(f3, off);
    model_pred[idx] = (off < 0);
    model_tgt[idx]  = idx * 4 + off;
  endtask

  task automatic build_program();
    // Filler is an ADDI carrying its own word address and never a jump
    for (int i = 0; i < IMEM_WORDS; i++) begin
      model_mem[i]  = {4'h0, i[`IMEM_AW-1:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
      model_pred[i] = 1'b0;
      model_tgt[i]  = '0;
    end
    model_mem[16] = addi_word(5'd1, 12'd1);
    model_mem[17] = addi_word(5'd2, 12'd2);
    // beq forward to word 21
    // Not predicted so fetch falls through to 19
    add_branch(18, 3'b000, 12);
    model_mem[19] = addi_word(5'd3, 12'd3);
    // Skips words 21 to 23
    add_jal(20, 16);
    model_mem[24] = addi_word(5'd4, 12'd4);
    model_mem[25] = addi_word(5'd5, 12'd5);
    // bne back to word 16
    add_branch(26, 3'b001, -40);
    model_mem[38] = addi_word(5'd6, 12'd6);
    model_mem[39] = addi_word(5'd7, 12'd7);
    add_jal(40, -8);
  endtask

  task automatic load_memory();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_waddr <= i[`IMEM_AW-1:0];
      imem_wdata <= model_mem[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  // One-cycle redirect pulse with id_stall set alongside it
  task automatic send_redirect(input logic [`FETCH_XLEN-1:0] target, input logic stall);
    @(posedge clk);
    redirect        <= 1'b1;
    redirect_target <= target;
    id_stall        <= stall;
    @(posedge clk);
    redirect <= 1'b0;
  endtask

  // Keeps going until count instructions were delivered
  // Random stalls on request
  task automatic run_deliveries(input int count, input logic random_stall);
    int start;
    start = delivered_cnt;
    while (delivered_cnt - start < count) begin
      @(posedge clk);
      if (random_stall) begin
        id_stall <= ($urandom % 2) == 1;
      end else begin
        id_stall <= 1'b0;
      end
    end
  endtask

  // Checker on the values sampled just before each edge
  always @(posedge clk) begin
    if (!rst_n) begin
      tracking      <= 1'b0;
      exp_valid     <= 1'b0;
      exp_pc        <= '0;
      hold_prev     <= 1'b0;
      delivered_cnt <= 0;
    end else begin
      if (tracking) begin
        assert (valid == exp_valid) else mismatch("valid", 32'(valid), 32'(exp_valid));
        // Everything towards decode freezes through a stall
        if (hold_prev) begin
          assert (instr == prev_instr) else mismatch("instr", instr, prev_instr);
          assert (pc == prev_pc) else mismatch("pc", pc, prev_pc);
          assert (pc_plus4 == prev_pc_plus4) else mismatch("pc_plus4", pc_plus4, prev_pc_plus4);
          assert (pred_taken == prev_pred)
            else mismatch("pred_taken", 32'(pred_taken), 32'(prev_pred));
          assert (valid == prev_valid) else mismatch("valid", 32'(valid), 32'(prev_valid));
        end
        if (valid) begin
          assert (pc == exp_pc) else mismatch("pc", pc, exp_pc);
          assert (instr == model_mem[exp_idx]) else mismatch("instr", instr, model_mem[exp_idx]);
          assert (pc_plus4 == exp_pc + 32'd4) else mismatch("pc_plus4", pc_plus4, exp_pc + 32'd4);
          assert (pred_taken == model_pred[exp_idx])
            else mismatch("pred_taken", 32'(pred_taken), 32'(model_pred[exp_idx]));
        end else begin
          assert (!pred_taken) else mismatch("pred_taken", 32'(pred_taken), 32'd0);
        end
      end
      prev_instr    <= instr;
      prev_pc       <= pc;
      prev_pc_plus4 <= pc_plus4;
      prev_pred     <= pred_taken;
      prev_valid    <= valid;
      hold_prev     <= id_stall && !redirect;
      if (redirect) begin
        // Bubble next cycle and target right after
        tracking  <= 1'b1;
        exp_valid <= 1'b0;
        exp_pc    <= redirect_target;
      end else if (tracking && !id_stall) begin
        if (valid) begin
          delivered_cnt <= delivered_cnt + 1;
          if (record_sel == 1) begin
            pcs_plain.push_back(pc);
          end else if (record_sel == 2) begin
            pcs_stalled.push_back(pc);
          end
          // Predicted word costs one bubble
          exp_valid <= !model_pred[exp_idx];
          exp_pc    <= model_pred[exp_idx] ? model_tgt[exp_idx] : exp_pc + 32'd4;
        end else begin
          exp_valid <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
        abort_with($sformatf("timeout, the run did not end within %0d cycles", MAX_CYCLES));
      end
    end
  end

  initial begin
    void'($urandom(83067));
    rst_n           <= 1'b0;
    imem_we         <= 1'b0;
    imem_waddr      <= '0;
    imem_wdata      <= '0;
    redirect        <= 1'b0;
    redirect_target <= '0;
    id_stall        <= 1'b0;
    record_sel      <= 0;
    build_program();

    repeat (2) @(posedge clk);
    // State left by reset
    assert (!valid) else mismatch("valid", 32'(valid), 32'd0);
    assert (!pred_taken) else mismatch("pred_taken", 32'(pred_taken), 32'd0);
    assert (i_fetch_top.i_if_stage.pc == `FETCH_RESET_PC)
      else mismatch("if_stage pc", i_fetch_top.i_if_stage.pc, `FETCH_RESET_PC);
    assert (i_fetch_top.imem_ren) else mismatch("imem_ren", 32'(i_fetch_top.imem_ren), 32'd1);
    rst_n <= 1'b1;

    // Decode held while the program goes in
    @(posedge clk);
    id_stall <= 1'b1;
    load_memory();

    // Redirect during a stall and then a clean run
    send_redirect(LOOP_BASE, 1'b1);
    record_sel <= 1;
    run_deliveries(RUN_LEN, 1'b0);
    record_sel <= 0;

    // Same loop under random back-pressure
    send_redirect(LOOP_BASE, 1'b1);
    record_sel <= 2;
    run_deliveries(RUN_LEN, 1'b1);
    record_sel <= 0;

    for (int i = 0; i < RUN_LEN; i++) begin
      assert (pcs_stalled[i] == pcs_plain[i])
        else mismatch("delivered pc under stall", pcs_stalled[i], pcs_plain[i]);
    end

    // Backward JAL loop
    send_redirect(JAL_BASE, 1'b0);
    run_deliveries(16, 1'b0);
    repeat (2) @(posedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
